//--- Makefile
TOP := tb_keyboard_display
LOG := sim.log

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run the testbench, check the log"
	@echo "  clean  remove build output and the log"
	@echo "  help   show this list"

test:
	verilator --binary --timing --assert -f vlog.f --top-module $(TOP) -Mdir obj_dir -o sim
	./obj_dir/sim | tee $(LOG)
	@grep -q "Simulation passed" $(LOG) || (echo "test failed, see $(LOG)" && exit 1)
	@echo "test passed"

clean:
	rm -rf obj_dir $(LOG)

//--- dv/tb_keyboard_display.sv
`default_nettype none

module tb_keyboard_display;

    localparam int refresh = 4;
    localparam int half_period = 20;            // system clocks per ps2 clock phase
    localparam int scan_cycles = 2 * display_pkg::NUM_DIGITS * refresh + 2;
    localparam int frames_sent = 12;
    localparam int timeout_cycles = frames_sent * 22 * half_period + 2000;

    logic clk;
    logic reset;
    logic ps2_clk;
    logic ps2_data;
    display_pkg::segment_t      segment_out;
    display_pkg::digit_enable_t digit_enable;
    ps2_pkg::scan_code_t        led_scan_code;

    int value_errors = 0;
    int other_errors = 0;
    int cycle_count = 0;
    int seed_result;

    ps2_pkg::code_history_t exp_history;        // model of what the display should hold
    display_pkg::segment_t  captured [display_pkg::NUM_DIGITS];
    logic                   seen [display_pkg::NUM_DIGITS];

    // standard active-low hex glyphs with dp off
    display_pkg::segment_t hex_segments [16] = '{
        8'hC0, 8'hF9, 8'hA4, 8'hB0, 8'h99, 8'h92, 8'h82, 8'hF8,
        8'h80, 8'h90, 8'h88, 8'h83, 8'hC6, 8'hA1, 8'h86, 8'h8E
    };

    keyboard_display_top #(
        .refresh_cycles (refresh)
    ) i_dut (
        .clk           (clk),
        .reset         (reset),
        .ps2_clk       (ps2_clk),
        .ps2_data      (ps2_data),
        .segment_out   (segment_out),
        .digit_enable  (digit_enable),
        .led_scan_code (led_scan_code)
    );

    initial clk = 1'b0;
    always #50 clk = ~clk;

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= timeout_cycles) begin
            $display("run stopped after %0d cycles without finishing the tests", cycle_count);
            $display("Simulation failed");
            $finish;
        end
    end

    task automatic check_scan_code(input ps2_pkg::scan_code_t got, input ps2_pkg::scan_code_t exp);
        if (got !== exp) begin
            value_errors++;
            $display("ERR %0t led_scan_code got %h expected %h", $time, got, exp);
        end
    endtask

    task automatic check_segments(input int digit, input display_pkg::segment_t got,
                                  input display_pkg::segment_t exp);
        if (got !== exp) begin
            value_errors++;
            $display("ERR %0t segment_out[digit %0d] got %h expected %h", $time, digit, got, exp);
        end
    endtask

    task automatic check_enable(input display_pkg::digit_enable_t got,
                                input display_pkg::digit_enable_t exp);
        if (got !== exp) begin
            value_errors++;
            $display("ERR %0t digit_enable got %b expected %b", $time, got, exp);
        end
    endtask

    // anode pattern with only the given digit low
    function automatic display_pkg::digit_enable_t one_low_mask(input int digit);
        display_pkg::digit_enable_t mask;
        for (int b = 0; b < display_pkg::NUM_DIGITS; b++)
            mask[b] = (b != digit);
        return mask;
    endfunction

    // wait n rising edges and step past the edge before driving
    task automatic hold(input int n);
        repeat (n) @(posedge clk);
        #10;
    endtask

    // data changes while the ps2 clock is high
    task automatic send_frame(input ps2_pkg::scan_code_t code, input logic bad_parity,
                              input logic bad_stop);
        logic [10:0] frame;
        logic        parity;
        parity = ~^code ^ bad_parity;   // odd parity over data and parity
        frame = {~bad_stop, parity, code, 1'b0};
        for (int i = 0; i < 11; i++) begin
            ps2_data = frame[i];
            hold(half_period);
            ps2_clk = 1'b0;
            hold(half_period);
            ps2_clk = 1'b1;
        end
        ps2_data = 1'b1;
        hold(half_period);
    endtask

    task automatic record_make(input ps2_pkg::scan_code_t code);
        exp_history = {exp_history[23:0], code};
    endtask

    // follow the scan for two rounds one anode at a time
    task automatic capture_display();
        int cur;
        cur = -1;
        for (int d = 0; d < display_pkg::NUM_DIGITS; d++)
            seen[d] = 1'b0;
        for (int c = 0; c < scan_cycles; c++) begin
            @(negedge clk);
            if (cur < 0) begin
                for (int b = 0; b < display_pkg::NUM_DIGITS; b++)
                    if (!digit_enable[b]) cur = b;
                if (cur >= 0)
                    check_enable(digit_enable, one_low_mask(cur));
            end else if (digit_enable !== one_low_mask(cur)) begin
                cur = (cur + 1) % display_pkg::NUM_DIGITS;
                check_enable(digit_enable, one_low_mask(cur));
            end
            if (cur >= 0) begin
                captured[cur] = segment_out;
                seen[cur] = 1'b1;
            end
        end
    endtask

    task automatic check_display();
        capture_display();
        check_scan_code(led_scan_code, exp_history[7:0]);
        for (int d = 0; d < display_pkg::NUM_DIGITS; d++) begin
            if (!seen[d]) begin
                other_errors++;
                $display("digit %0d was never enabled during the scan", d);
            end else begin
                check_segments(d, captured[d], hex_segments[exp_history[4*d +: 4]]);
            end
        end
    endtask

    task automatic test_reset_state();
        check_display();
    endtask

    task automatic test_single_make();
        send_frame(8'h1C, 1'b0, 1'b0);
        record_make(8'h1C);
        check_display();
    endtask

    task automatic test_random_makes();
        ps2_pkg::scan_code_t code;
        for (int n = 0; n < 6; n++) begin
            code = ps2_pkg::scan_code_t'($urandom);
            while (code == ps2_pkg::BREAK_PREFIX)
                code = ps2_pkg::scan_code_t'($urandom);
            send_frame(code, 1'b0, 1'b0);
            record_make(code);
        end
        check_display();
    endtask

    task automatic test_break_sequence();
        send_frame(ps2_pkg::BREAK_PREFIX, 1'b0, 1'b0);
        send_frame(8'h1C, 1'b0, 1'b0);      // released key is not recorded
        check_display();
    endtask

    task automatic test_bad_frames();
        send_frame(8'h33, 1'b1, 1'b0);
        send_frame(8'h44, 1'b0, 1'b1);
        check_display();
        send_frame(8'h2A, 1'b0, 1'b0);
        record_make(8'h2A);
        check_display();
    endtask

    initial begin
        seed_result = $urandom(70267);
        reset = 1'b1;
        ps2_clk = 1'b1;
        ps2_data = 1'b1;
        exp_history = '0;
        repeat (15) @(posedge clk);
        @(negedge clk);
        check_enable(digit_enable, 8'hFE);   // digit 0 while in reset
        @(posedge clk);
        #10;
        reset = 1'b0;

        test_reset_state();
        test_single_make();
        test_random_makes();
        test_break_sequence();
        test_bad_frames();

        $display("errors: %0d value mismatches, %0d other failures", value_errors, other_errors);
        if (value_errors == 0 && other_errors == 0) begin
            $display("Simulation passed");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- hdl/digit_scanner.sv
`default_nettype none

module digit_scanner #(
    parameter int refresh_cycles = 100000
) (
    input  logic                       clk,
    input  logic                       reset,
    input  display_pkg::segment_t      digit_segments [display_pkg::NUM_DIGITS],
    output display_pkg::segment_t      segment_out,
    output display_pkg::digit_enable_t digit_enable
);

    localparam int cnt_w = (refresh_cycles > 1) ? $clog2(refresh_cycles) : 1;
    localparam int idx_w = $clog2(display_pkg::NUM_DIGITS);

    logic [cnt_w-1:0] refresh_cnt;
    logic [idx_w-1:0] digit_idx;

    always_ff @(posedge clk) begin
        if (reset) begin
            refresh_cnt  <= '0;
            digit_idx    <= '0;
            digit_enable <= ~display_pkg::digit_enable_t'(1);  // digit 0
        end else begin
            if (refresh_cnt == cnt_w'(refresh_cycles - 1)) begin
                refresh_cnt <= '0;
                digit_idx   <= digit_idx + 1'b1;  // wraps 7 -> 0
            end else begin
                refresh_cnt <= refresh_cnt + 1'b1;
            end
            digit_enable <= ~(display_pkg::digit_enable_t'(1) << digit_idx);
        end
    end

    // same index selects the pattern, so cathodes track the anode mask
    always_ff @(posedge clk) begin
        segment_out <= digit_segments[digit_idx];
    end

    a_one_anode_low: assert property (
        @(posedge clk) disable iff (reset) $onehot(~digit_enable)
    );

endmodule

`default_nettype wire

//--- hdl/display_pkg.sv
`default_nettype none

package display_pkg;

    // one digit per history nibble
    parameter int NUM_DIGITS = 8;

    typedef logic [3:0] nibble_t;

    // active low cathodes
    // bit 0 = a ... bit 6 = g, bit 7 = dp
    typedef logic [7:0] segment_t;

    // active low anodes, bit i drives digit i
    typedef logic [NUM_DIGITS-1:0] digit_enable_t;

    // blank pattern, every segment off
    parameter segment_t SEGMENTS_OFF = 8'hFF;

endpackage

`default_nettype wire

//--- hdl/keyboard_display_top.sv
`default_nettype none

module keyboard_display_top #(
    parameter int refresh_cycles = 100000
) (
    input  logic                       clk,
    input  logic                       reset,
    input  logic                       ps2_clk,
    input  logic                       ps2_data,
    output display_pkg::segment_t      segment_out,
    output display_pkg::digit_enable_t digit_enable,
    output ps2_pkg::scan_code_t        led_scan_code
);

    logic                   sample_strobe;
    logic                   ps2_data_synced;
    ps2_pkg::scan_code_t    scan_code;
    logic                   scan_code_valid;
    ps2_pkg::code_history_t history;
    display_pkg::segment_t  digit_segments [display_pkg::NUM_DIGITS];

    ps2_input_sync u_input_sync (
        .clk             (clk),
        .reset           (reset),
        .ps2_clk         (ps2_clk),
        .ps2_data        (ps2_data),
        .sample_strobe   (sample_strobe),
        .ps2_data_synced (ps2_data_synced)
    );

    ps2_frame_receiver u_frame_receiver (
        .clk             (clk),
        .reset           (reset),
        .sample_strobe   (sample_strobe),
        .ps2_data_synced (ps2_data_synced),
        .scan_code       (scan_code),
        .scan_code_valid (scan_code_valid),
        .frame_error     ()
    );

    scan_code_history u_history (
        .clk             (clk),
        .reset           (reset),
        .scan_code       (scan_code),
        .scan_code_valid (scan_code_valid),
        .history         (history)
    );

    // digit i shows history nibble i
    for (genvar i = 0; i < display_pkg::NUM_DIGITS; i++) begin : u_decoder
        segment_decoder u_seg (
            .nibble   (history[4*i +: 4]),
            .segments (digit_segments[i])
        );
    end

    digit_scanner #(
        .refresh_cycles (refresh_cycles)
    ) u_scanner (
        .clk            (clk),
        .reset          (reset),
        .digit_segments (digit_segments),
        .segment_out    (segment_out),
        .digit_enable   (digit_enable)
    );

    assign led_scan_code = history[7:0];  // newest make code

endmodule

`default_nettype wire

//--- hdl/ps2_frame_receiver.sv
`default_nettype none

module ps2_frame_receiver (
    input  logic               clk,
    input  logic               reset,
    input  logic               sample_strobe,
    input  logic               ps2_data_synced,
    output ps2_pkg::scan_code_t scan_code,
    output logic               scan_code_valid,
    output logic               frame_error
);

    typedef enum logic [1:0] {
        st_idle,
        st_data,
        st_parity,
        st_stop
    } state_t;

    state_t              state;
    logic [2:0]          bit_cnt;
    logic                parity_acc;   // xor of data and parity bits
    ps2_pkg::scan_code_t shift_reg;

    always_ff @(posedge clk) begin
        if (reset) begin
            state           <= st_idle;
            bit_cnt         <= '0;
            parity_acc      <= 1'b0;
            scan_code_valid <= 1'b0;
            frame_error     <= 1'b0;
        end else begin
            scan_code_valid <= 1'b0;
            frame_error     <= 1'b0;
            if (sample_strobe) begin
                case (state)
                    st_idle: begin
                        // a high start bit is just noise, stay put
                        if (!ps2_data_synced) begin
                            state      <= st_data;
                            bit_cnt    <= '0;
                            parity_acc <= 1'b0;
                        end
                    end
                    st_data: begin
                        parity_acc <= parity_acc ^ ps2_data_synced;
                        bit_cnt    <= bit_cnt + 3'd1;
                        if (bit_cnt == 3'd7)
                            state <= st_parity;
                    end
                    st_parity: begin
                        parity_acc <= parity_acc ^ ps2_data_synced;
                        state      <= st_stop;
                    end
                    st_stop: begin
                        // odd parity leaves the accumulator at 1
                        if (ps2_data_synced && parity_acc)
                            scan_code_valid <= 1'b1;
                        else
                            frame_error <= 1'b1;
                        state <= st_idle;
                    end
                    default: state <= st_idle;
                endcase
            end
        end
    end

    // lsb arrives first, so shift in from the top
    always_ff @(posedge clk) begin
        if (sample_strobe && state == st_data)
            shift_reg <= {ps2_data_synced, shift_reg[7:1]};
    end

    assign scan_code = shift_reg;

    a_valid_error_exclusive: assert property (
        @(posedge clk) disable iff (reset) !(scan_code_valid && frame_error)
    );

endmodule

`default_nettype wire

//--- hdl/ps2_input_sync.sv
`default_nettype none

module ps2_input_sync (
    input  logic clk,
    input  logic reset,
    input  logic ps2_clk,
    input  logic ps2_data,
    output logic sample_strobe,
    output logic ps2_data_synced
);

    logic clk_meta;
    logic clk_sync;
    logic clk_prev;     // last synchronized ps2 clock level
    logic data_meta;
    logic data_sync;

    // both lines idle high on the bus
    always_ff @(posedge clk) begin
        if (reset) begin
            clk_meta        <= 1'b1;
            clk_sync        <= 1'b1;
            clk_prev        <= 1'b1;
            data_meta       <= 1'b1;
            data_sync       <= 1'b1;
            ps2_data_synced <= 1'b1;
            sample_strobe   <= 1'b0;
        end else begin
            clk_meta  <= ps2_clk;
            clk_sync  <= clk_meta;
            clk_prev  <= clk_sync;
            data_meta <= ps2_data;
            data_sync <= data_meta;

            // third data flop keeps the bit aligned with the strobe
            ps2_data_synced <= data_sync;

            sample_strobe <= clk_prev & ~clk_sync;  // high to low
        end
    end

endmodule

`default_nettype wire

//--- hdl/ps2_pkg.sv
`default_nettype none

package ps2_pkg;

    // number of make codes kept for the display
    parameter int HISTORY_DEPTH = 4;

    typedef logic [7:0] scan_code_t;

    // newest code in the low byte
    typedef logic [HISTORY_DEPTH*8-1:0] code_history_t;

    // prefix sent ahead of the code on key release
    parameter scan_code_t BREAK_PREFIX = 8'hF0;

endpackage

`default_nettype wire

//--- hdl/scan_code_history.sv
`default_nettype none

module scan_code_history (
    input  logic                  clk,
    input  logic                  reset,
    input  ps2_pkg::scan_code_t   scan_code,
    input  logic                  scan_code_valid,
    output ps2_pkg::code_history_t history
);

    typedef enum logic {
        st_make,
        st_after_break
    } state_t;

    state_t state;

    always_ff @(posedge clk) begin
        if (reset) begin
            state   <= st_make;
            history <= '0;
        end else if (scan_code_valid) begin
            case (state)
                st_make: begin
                    if (scan_code == ps2_pkg::BREAK_PREFIX) begin
                        state <= st_after_break;   // prefix not stored
                    end else begin
                        // oldest byte drops off the top
                        history <= {history[$bits(history)-9:0], scan_code};
                    end
                end
                st_after_break: begin
                    // released key code, skip it
                    state <= st_make;
                end
                default: state <= st_make;
            endcase
        end
    end

    // only a received code may touch the history
    a_history_needs_code: assert property (
        @(posedge clk) disable iff (reset)
            !$past(scan_code_valid) |-> $stable(history)
    );

endmodule

`default_nettype wire

//--- hdl/segment_decoder.sv
`default_nettype none

module segment_decoder (
    input  display_pkg::nibble_t  nibble,
    output display_pkg::segment_t segments
);

    // patterns are dp,g..a with a low bit lighting the segment
    always_comb begin
        case (nibble)
            4'h0: segments = 8'hC0;
            4'h1: segments = 8'hF9;
            4'h2: segments = 8'hA4;
            4'h3: segments = 8'hB0;
            4'h4: segments = 8'h99;
            4'h5: segments = 8'h92;
            4'h6: segments = 8'h82;
            4'h7: segments = 8'hF8;
            4'h8: segments = 8'h80;
            4'h9: segments = 8'h90;
            4'hA: segments = 8'h88;
            4'hB: segments = 8'h83;  // lower case b
            4'hC: segments = 8'hC6;
            4'hD: segments = 8'hA1;  // lower case d
            4'hE: segments = 8'h86;
            4'hF: segments = 8'h8E;
            default: segments = display_pkg::SEGMENTS_OFF;
        endcase
    end

endmodule

`default_nettype wire

//--- vlog.f
hdl/ps2_pkg.sv
hdl/display_pkg.sv
hdl/ps2_input_sync.sv
hdl/ps2_frame_receiver.sv
hdl/scan_code_history.sv
hdl/segment_decoder.sv
hdl/digit_scanner.sv
hdl/keyboard_display_top.sv
dv/tb_keyboard_display.sv
